// File: vlog.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_imm_gen.sv
rv_ctrl_decode.sv
rv_decode_stage.sv
rv_decode_stage_assertions.sv
tb_rv_decode_stage.sv

// File: Bender.yml
package:
  name: rv_decode_stage

sources:
  - rv_isa_pkg.sv
  - rv_ctrl_pkg.sv
  - rv_imm_gen.sv
  - rv_ctrl_decode.sv
  - rv_decode_stage.sv
  - target: test
    files:
      - rv_decode_stage_assertions.sv
      - tb_rv_decode_stage.sv

// File: tb_rv_decode_stage.sv
// Testbench for the RV32IM decode stage
// Directed and random instruction stream with idle gaps

`timescale 1ns/1ns

module tb_rv_decode_stage
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        dec_valid;
    decoded_t    dec;

    integer      seed;
    int          issued = 0;
    int          timeouts = 0;
    int          misses = 0;
    int          fails;
    int          errors;
    logic        valid_seen = 1'b0;

    // NOP, SUB, SRA, MUL, REMU, load with funct3 7, ECALL
    logic [31:0] directed [7] = '{32'h00000013, 32'h402081b3, 32'h4020d1b3, 32'h022081b3,
                                  32'h0220f1b3, 32'h0000f183, 32'h00000073};
    logic [6:0]  ops [10] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
                              OP_LOAD, OP_STORE, OP_IMM, OP_REG, OP_SYSTEM};

    rv_decode_stage rv_decode_stage_i (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    bind rv_decode_stage rv_decode_stage_assertions rv_decode_stage_assertions_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk)
    begin
        if (dec_valid === 1'b1)
        begin
            valid_seen <= 1'b1;
        end
    end

    // Mostly legal opcodes with funct7 biased toward the legal values
    task automatic pick_instr(output logic [31:0] word);
        logic [31:0] r;
        r    = $random(seed);
        word = $random(seed);
        if (r[2:0] != 3'd0)
        begin
            word[6:0] = ops[r[7:3] % 10];
        end
        case (r[10:9])
            2'd0:    word[31:25] = 7'h00;
            2'd1:    word[31:25] = 7'h20;
            2'd2:    word[31:25] = 7'h01;
        endcase
    endtask

    task automatic issue(input logic [31:0] word);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        issued++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = $random(seed);                // Must not reach the output
    endtask

    initial
    begin
        logic [31:0] word;
        logic [31:0] r;
        int          cycles;

        seed        = 32'h407fdd11;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (dec_valid !== 1'b0 && cycles < 5)
        begin
            @(negedge clk);
            cycles++;
        end
        if (dec_valid !== 1'b0)
        begin
            timeouts++;
            $display("Timed out waiting for dec_valid_o to clear after reset");
        end

        for (int n = 0; n < 400; n++)
        begin
            if (n < 7)
            begin
                word = directed[n];
            end
            else
            begin
                pick_instr(word);
            end
            r = $random(seed);
            if (r[1:0] == 2'd0)
            begin
                idle_cycle();
            end
            issue(word);
        end
        idle_cycle();

        // Drain the last bundle
        cycles = 0;
        while (dec_valid !== 1'b0 && cycles < 10)
        begin
            @(negedge clk);
            cycles++;
        end
        if (dec_valid !== 1'b0)
        begin
            timeouts++;
            $display("Timed out draining, dec_valid_o still high");
        end
        if (!valid_seen)
        begin
            misses++;
            $display("No valid output was ever seen on dec_valid_o");
        end

        fails  = rv_decode_stage_i.rv_decode_stage_assertions_i.fail_count;
        errors = timeouts + misses + fails;
        $display("Issued %0d instructions, %0d errors (%0d timeouts, %0d misses, %0d asserts)",
                 issued, errors, timeouts, misses, fails);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: rv_decode_stage_assertions.sv
// Decode stage checks, bound to the DUT
// Rebuilds the expected bundle fields from the previous valid instruction
// and compares them with the registered outputs

`timescale 1ns/1ns

module rv_decode_stage_assertions
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input logic            clk_i,
    input logic            reset_i,
    input logic            instr_valid_i,
    input logic [XLEN-1:0] instr_i,
    input logic            dec_valid_o,
    input decoded_t        dec_o
);

    int              fail_count = 0;                // Read by the testbench
    logic [XLEN-1:0] prev;                          // Instruction of the last edge
    logic            chk;                           // Bundle was loaded from prev
    logic            was_reset;
    decoded_t        last_dec;                      // Bundle before the last edge
    logic [6:0]      op;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic [XLEN-1:0] exp_imm;
    logic            exp_ill;
    alu_op_e         exp_alu;
    cmp_op_e         exp_cmp;
    wb_sel_e         exp_wb;
    ctrl_t           c;

    always_ff @(posedge clk_i)
    begin
        prev      <= instr_i;
        chk       <= instr_valid_i && !reset_i;
        was_reset <= reset_i;
        last_dec  <= dec_o;
    end

    assign op = prev[6:0];
    assign f3 = prev[14:12];
    assign f7 = prev[31:25];
    assign c  = dec_o.ctrl;

    //////////////////////////////
    // Expected values
    //////////////////////////////

    always_comb
    begin
        case (op)
            OP_JALR, OP_IMM, OP_LOAD: exp_imm = {{20{prev[31]}}, prev[31:20]};
            OP_STORE:         exp_imm = {{20{prev[31]}}, prev[31:25], prev[11:7]};
            OP_BRANCH:        exp_imm = {{20{prev[31]}}, prev[7], prev[30:25], prev[11:8], 1'b0};
            OP_LUI, OP_AUIPC: exp_imm = {prev[31:12], 12'h000};
            OP_JAL:           exp_imm = {{12{prev[31]}}, prev[19:12], prev[20], prev[30:21], 1'b0};
            default:          exp_imm = '0;
        endcase

        case (op)
            OP_LUI, OP_AUIPC, OP_JAL: exp_ill = 1'b0;
            OP_JALR:   exp_ill = (f3 != 3'd0);
            OP_BRANCH: exp_ill = (f3 == 3'd2) || (f3 == 3'd3);
            OP_LOAD:   exp_ill = (f3 == 3'd3) || (f3 >= 3'd6);
            OP_STORE:  exp_ill = (f3 > 3'd2);
            OP_IMM:    exp_ill = (f3 == 3'd1 && f7 != 7'h00) ||
                                 (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            OP_REG:    exp_ill = !(f7 == 7'h00 || f7 == 7'h01 ||
                                   (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            default:   exp_ill = 1'b1;              // SYSTEM and unknown
        endcase

        case (f3)
            3'd0:    exp_cmp = CMP_EQ;
            3'd1:    exp_cmp = CMP_NE;
            3'd4:    exp_cmp = CMP_LT;
            3'd5:    exp_cmp = CMP_GE;
            3'd6:    exp_cmp = CMP_LTU;
            3'd7:    exp_cmp = CMP_GEU;
            default: exp_cmp = CMP_UN;
        endcase

        // RV32IM register op table
        case ({f7, f3})
            {7'h00, 3'd0}: exp_alu = ALU_ADD;
            {7'h20, 3'd0}: exp_alu = ALU_SUB;
            {7'h00, 3'd1}: exp_alu = ALU_SLL;
            {7'h00, 3'd4}: exp_alu = ALU_XOR;
            {7'h00, 3'd5}: exp_alu = ALU_SRL;
            {7'h20, 3'd5}: exp_alu = ALU_SRA;
            {7'h00, 3'd6}: exp_alu = ALU_OR;
            {7'h00, 3'd7}: exp_alu = ALU_AND;
            {7'h01, 3'd0}: exp_alu = ALU_MUL;
            {7'h01, 3'd1}: exp_alu = ALU_MULH;
            {7'h01, 3'd2}: exp_alu = ALU_MULHSU;
            {7'h01, 3'd3}: exp_alu = ALU_MULHU;
            {7'h01, 3'd4}: exp_alu = ALU_DIV;
            {7'h01, 3'd5}: exp_alu = ALU_DIVU;
            {7'h01, 3'd6}: exp_alu = ALU_REM;
            {7'h01, 3'd7}: exp_alu = ALU_REMU;
            default:       exp_alu = ALU_ADD;
        endcase

        if (f7 != 7'h01 && f3[2:1] == 2'b01)
        begin
            exp_wb = WB_CMP;                        // SLT, SLTU
        end
        else
        begin
            exp_wb = WB_ALU;
        end
    end

    //////////////////////////////
    // Checks on the falling edge
    //////////////////////////////

    // chk is unknown only before the first clock edge
    a_valid: assert property (@(negedge clk_i) !$isunknown(chk) |-> dec_valid_o == chk)
    else
    begin
        fail_count++;
        $error("ERROR dec_valid_o got %h exp %h", dec_valid_o, chk);
    end

    a_reset: assert property (@(negedge clk_i) was_reset |->
        {dec_valid_o, c.rf_we, c.mem_we, c.mem_req, c.jump_en, dec_o.illegal} == 6'b0)
    else
    begin
        fail_count++;
        $error("ERROR enables after reset got %h exp 00",
               {dec_valid_o, c.rf_we, c.mem_we, c.mem_req, c.jump_en, dec_o.illegal});
    end

    // Bundle holds across idle cycles
    a_hold: assert property (@(negedge clk_i) !chk && !was_reset |-> dec_o === last_dec)
    else
    begin
        fail_count++;
        $error("ERROR dec_o changed while idle got %h exp %h", dec_o, last_dec);
    end

    a_fields: assert property (@(negedge clk_i) chk |->
        {dec_o.imm, dec_o.rd, dec_o.rs1, dec_o.rs2} ==
        {exp_imm, prev[11:7], prev[19:15], prev[24:20]})
    else
    begin
        fail_count++;
        $error("ERROR imm/rd/rs1/rs2 got %h exp %h",
               {dec_o.imm, dec_o.rd, dec_o.rs1, dec_o.rs2},
               {exp_imm, prev[11:7], prev[19:15], prev[24:20]});
    end

    a_illegal: assert property (@(negedge clk_i) chk |-> dec_o.illegal == exp_ill)
    else
    begin
        fail_count++;
        $error("ERROR dec_o.illegal got %h exp %h for instr %h", dec_o.illegal, exp_ill, prev);
    end

    a_quiet: assert property (@(negedge clk_i) chk && exp_ill |->
        {c.rf_we, c.mem_we, c.mem_req, c.jump_en} == 4'b0)
    else
    begin
        fail_count++;
        $error("ERROR enables of illegal got %h exp 0",
               {c.rf_we, c.mem_we, c.mem_req, c.jump_en});
    end

    a_lui: assert property (@(negedge clk_i) chk && op == OP_LUI |->
        {c.rf_we, c.wb_sel} == {1'b1, WB_IMM})
    else
    begin
        fail_count++;
        $error("ERROR lui rf_we/wb_sel got %h exp %h", {c.rf_we, c.wb_sel}, {1'b1, WB_IMM});
    end

    a_auipc: assert property (@(negedge clk_i) chk && op == OP_AUIPC |->
        {c.rf_we, c.a_sel_pc, c.b_sel_imm, c.wb_sel} == {3'b111, WB_ALU})
    else
    begin
        fail_count++;
        $error("ERROR auipc ctrl got %h exp %h",
               {c.rf_we, c.a_sel_pc, c.b_sel_imm, c.wb_sel}, {3'b111, WB_ALU});
    end

    // SLTI and SLTIU compare against the immediate
    a_set_imm: assert property (@(negedge clk_i) chk && op == OP_IMM && f3[2:1] == 2'b01 |->
        {c.wb_sel, c.cmp_b_sel_imm} == {WB_CMP, 1'b1})
    else
    begin
        fail_count++;
        $error("ERROR slti wb_sel/cmp_b_sel_imm got %h exp %h",
               {c.wb_sel, c.cmp_b_sel_imm}, {WB_CMP, 1'b1});
    end

    a_load: assert property (@(negedge clk_i) chk && op == OP_LOAD && !exp_ill |->
        {c.mem_req, c.mem_we, c.rf_we, c.wb_sel, c.mem_width} == {3'b101, WB_MEM, f3})
    else
    begin
        fail_count++;
        $error("ERROR load ctrl got %h exp %h",
               {c.mem_req, c.mem_we, c.rf_we, c.wb_sel, c.mem_width}, {3'b101, WB_MEM, f3});
    end

    a_store: assert property (@(negedge clk_i) chk && op == OP_STORE && !exp_ill |->
        {c.mem_req, c.mem_we, c.rf_we, c.mem_width} == {3'b110, f3})
    else
    begin
        fail_count++;
        $error("ERROR store ctrl got %h exp %h",
               {c.mem_req, c.mem_we, c.rf_we, c.mem_width}, {3'b110, f3});
    end

    a_branch: assert property (@(negedge clk_i) chk && op == OP_BRANCH && !exp_ill |->
        {c.jump_en, c.cmp_op} == {1'b1, exp_cmp})
    else
    begin
        fail_count++;
        $error("ERROR branch jump_en/cmp_op got %h exp %h",
               {c.jump_en, c.cmp_op}, {1'b1, exp_cmp});
    end

    // ALU op is a don't care for SLT and SLTU
    a_reg_op: assert property (@(negedge clk_i) chk && op == OP_REG && !exp_ill |->
        c.wb_sel == exp_wb && (exp_wb == WB_CMP || c.alu_op == exp_alu))
    else
    begin
        fail_count++;
        $error("ERROR reg op wb_sel/alu_op got %h exp %h",
               {c.wb_sel, c.alu_op}, {exp_wb, exp_alu});
    end

endmodule

// File: rv_decode_stage.sv
// Registered RV32IM decode stage
// Splits instruction fields, runs control and immediate decode and
// registers the bundle one cycle later. No back-pressure.

`timescale 1ns/1ns

module rv_decode_stage
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    output logic            dec_valid_o,
    output decoded_t        dec_o
);

    instr_fields_t  fields;
    imm_fmt_e       imm_fmt;
    decoded_t       dec_d;

    assign fields = instr_fields_t'(instr_i);

    rv_ctrl_decode rv_ctrl_decode_i (
        .fields_i  (fields),
        .ctrl_o    (dec_d.ctrl),
        .imm_fmt_o (imm_fmt),
        .illegal_o (dec_d.illegal)
    );

    rv_imm_gen rv_imm_gen_i (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (dec_d.imm)
    );

    assign dec_d.rd  = fields.rd;
    assign dec_d.rs1 = fields.rs1;
    assign dec_d.rs2 = fields.rs2;

    ///////////////////////////////
    // Output register
    ///////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (instr_valid_i)
        begin
            dec_o <= dec_d;                         // Hold when no valid input
        end
        if (reset_i)
        begin
            dec_valid_o           <= 1'b0;
            dec_o.ctrl.rf_we      <= 1'b0;
            dec_o.ctrl.jump_en    <= 1'b0;
            dec_o.ctrl.mem_req    <= 1'b0;
            dec_o.ctrl.mem_we     <= 1'b0;
            dec_o.illegal         <= 1'b0;
        end
        else
        begin
            dec_valid_o <= instr_valid_i;
        end
    end

endmodule

// File: rv_ctrl_decode.sv
// Control decoder for RV32IM
// Maps opcode and funct fields to the control word, immediate format and
// illegal flag. SYSTEM, unknown opcodes and bad funct codes are illegal.

`timescale 1ns/1ns

module rv_ctrl_decode
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  instr_fields_t fields_i,
    output ctrl_t         ctrl_o,
    output imm_fmt_e      imm_fmt_o,
    output logic          illegal_o
);

    // Shared funct3 map for OP and OP-IMM
    function automatic alu_op_e base_alu_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb
    begin
        logic is_imm;
        logic alt;

        is_imm = (fields_i.opcode == OP_IMM);
        alt    = (fields_i.funct7 == FUNCT7_ALT);

        ///////////////////////////////
        // Safe defaults
        ///////////////////////////////
        ctrl_o           = '0;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.cmp_op    = CMP_UN;
        ctrl_o.wb_sel    = WB_ALU;
        ctrl_o.mem_width = fields_i.funct3;
        imm_fmt_o        = IMM_NONE;
        illegal_o        = 1'b0;

        case (fields_i.opcode)
            OP_LUI:
            begin
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.wb_sel = WB_IMM;
                imm_fmt_o     = IMM_U;
            end
            OP_AUIPC:
            begin
                ctrl_o.rf_we     = 1'b1;
                ctrl_o.a_sel_pc  = 1'b1;            // PC + imm
                ctrl_o.b_sel_imm = 1'b1;
                imm_fmt_o        = IMM_U;
            end
            OP_JAL, OP_JALR:
            begin
                ctrl_o.jump_en   = 1'b1;
                ctrl_o.rf_we     = 1'b1;
                ctrl_o.wb_sel    = WB_PC_LINK;
                ctrl_o.a_sel_pc  = (fields_i.opcode == OP_JAL);
                ctrl_o.b_sel_imm = 1'b1;
                imm_fmt_o        = (fields_i.opcode == OP_JAL) ? IMM_J : IMM_I;
                illegal_o        = (fields_i.opcode == OP_JALR) && (fields_i.funct3 != 3'b000);
            end
            OP_BRANCH:
            begin
                ctrl_o.jump_en   = 1'b1;
                ctrl_o.a_sel_pc  = 1'b1;            // Target is PC + imm
                ctrl_o.b_sel_imm = 1'b1;
                imm_fmt_o        = IMM_B;
                case (fields_i.funct3)
                    3'b000:  ctrl_o.cmp_op = CMP_EQ;
                    3'b001:  ctrl_o.cmp_op = CMP_NE;
                    3'b100:  ctrl_o.cmp_op = CMP_LT;
                    3'b101:  ctrl_o.cmp_op = CMP_GE;
                    3'b110:  ctrl_o.cmp_op = CMP_LTU;
                    3'b111:  ctrl_o.cmp_op = CMP_GEU;
                    default: illegal_o     = 1'b1;
                endcase
            end
            OP_LOAD:
            begin
                ctrl_o.rf_we     = 1'b1;
                ctrl_o.wb_sel    = WB_MEM;
                ctrl_o.b_sel_imm = 1'b1;
                ctrl_o.mem_req   = 1'b1;
                imm_fmt_o        = IMM_I;
                illegal_o        = fields_i.funct3 inside {3'b011, 3'b110, 3'b111};
            end
            OP_STORE:
            begin
                ctrl_o.b_sel_imm = 1'b1;
                ctrl_o.mem_req   = 1'b1;
                ctrl_o.mem_we    = 1'b1;
                imm_fmt_o        = IMM_S;
                illegal_o        = (fields_i.funct3 > 3'b010);  // SB, SH, SW only
            end
            OP_IMM, OP_REG:
            begin
                ctrl_o.rf_we = 1'b1;
                if (is_imm)
                begin
                    imm_fmt_o = IMM_I;
                end
                if (!is_imm && fields_i.funct7 == FUNCT7_MULDIV)
                begin
                    ctrl_o.alu_op = alu_op_e'({1'b1, fields_i.funct3});
                end
                else
                begin
                    // funct7 only matters for shifts in OP-IMM
                    if (!is_imm || fields_i.funct3 inside {3'b001, 3'b101})
                    begin
                        illegal_o = !((fields_i.funct7 == FUNCT7_BASE) ||
                                      (alt && fields_i.funct3 inside {3'b000, 3'b101}));
                    end
                    case (fields_i.funct3)
                        3'b010, 3'b011:
                        begin
                            ctrl_o.wb_sel        = WB_CMP;
                            ctrl_o.cmp_op        = fields_i.funct3[0] ? CMP_LTU : CMP_LT;
                            ctrl_o.cmp_b_sel_imm = is_imm;
                        end
                        default:
                        begin
                            ctrl_o.b_sel_imm = is_imm;
                            ctrl_o.alu_op    = base_alu_op(fields_i.funct3,
                                alt && (!is_imm || fields_i.funct3 == 3'b101));
                        end
                    endcase
                end
            end
            default:
            begin
                illegal_o = 1'b1;                   // SYSTEM and unknown opcodes
            end
        endcase

        // Illegal instructions must have no side effects
        if (illegal_o)
        begin
            ctrl_o.rf_we   = 1'b0;
            ctrl_o.jump_en = 1'b0;
            ctrl_o.mem_req = 1'b0;
            ctrl_o.mem_we  = 1'b0;
        end
    end

endmodule

// File: rv_imm_gen.sv
// Immediate generator
// Reassembles and sign-extends the immediate of the selected format

`timescale 1ns/1ns

module rv_imm_gen
    import rv_isa_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    input  imm_fmt_e        fmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];                      // All formats extend from bit 31

    always_comb
    begin
        case (fmt_i)
            IMM_I:
            begin
                imm_o = {{(XLEN-11){sign}}, instr_i[30:20]};
            end
            IMM_S:
            begin
                imm_o = {{(XLEN-11){sign}}, instr_i[30:25], instr_i[11:7]};
            end
            IMM_B:
            begin
                imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};       // Halfword aligned
            end
            IMM_U:
            begin
                imm_o = {instr_i[XLEN-1:12], 12'b0};
            end
            IMM_J:
            begin
                imm_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default:
            begin
                imm_o = '0;                         // IMM_NONE
            end
        endcase
    end

endmodule

// File: rv_ctrl_pkg.sv
// Control-side definitions for the decode stage
// ALU, compare and write-back selects, control word and decoded bundle

package rv_ctrl_pkg;

    ///////////////////////////////
    // ALU operations
    ///////////////////////////////

    // M ops sit at 8..15 in funct3 order
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SRL    = 4'd3,
        ALU_SRA    = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_AND    = 4'd7,
        ALU_MUL    = 4'd8,
        ALU_MULH   = 4'd9,
        ALU_MULHSU = 4'd10,
        ALU_MULHU  = 4'd11,
        ALU_DIV    = 4'd12,
        ALU_DIVU   = 4'd13,
        ALU_REM    = 4'd14,
        ALU_REMU   = 4'd15
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_UN  = 3'd0,                             // Always taken
        CMP_EQ  = 3'd1,
        CMP_NE  = 3'd2,
        CMP_LT  = 3'd3,
        CMP_GE  = 3'd4,
        CMP_LTU = 3'd5,
        CMP_GEU = 3'd6
    } cmp_op_e;

    // Register file write-back source
    typedef enum logic [2:0] {
        WB_IMM     = 3'd0,
        WB_PC_LINK = 3'd1,                          // PC + 4
        WB_ALU     = 3'd2,
        WB_CMP     = 3'd3,
        WB_MEM     = 3'd4
    } wb_sel_e;

    ///////////////////////////////
    // Control word and bundle
    ///////////////////////////////

    typedef struct packed {
        alu_op_e    alu_op;
        cmp_op_e    cmp_op;
        wb_sel_e    wb_sel;
        logic       a_sel_pc;                       // A operand is PC
        logic       b_sel_imm;                      // B operand is immediate
        logic       cmp_b_sel_imm;                  // Compare against immediate
        logic       rf_we;
        logic       jump_en;
        logic       mem_req;
        logic       mem_we;
        logic [2:0] mem_width;                      // Raw funct3
    } ctrl_t;

    typedef struct packed {
        ctrl_t                            ctrl;
        logic [rv_isa_pkg::XLEN-1:0]      imm;
        logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
        logic [rv_isa_pkg::REG_IDX_W-1:0] rs1;
        logic [rv_isa_pkg::REG_IDX_W-1:0] rs2;
        logic                             illegal;
    } decoded_t;

endpackage

// File: rv_isa_pkg.sv
// RV32 instruction-set encodings
// Opcodes, funct7 values, immediate layouts and the field view of an instruction

package rv_isa_pkg;

    ///////////////////////////////
    // Widths
    ///////////////////////////////

    localparam int XLEN      = 32;                  // Data and instruction width
    localparam int REG_IDX_W = 5;                   // x0..x31

    ///////////////////////////////
    // Major opcodes
    ///////////////////////////////

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011                      // Not supported here
    } opcode_e;

    // Legal funct7 values for register ops and shifts
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // SUB, SRA, SRAI
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension

    ///////////////////////////////
    // Immediate formats
    ///////////////////////////////

    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_S    = 3'd1,
        IMM_B    = 3'd2,
        IMM_U    = 3'd3,
        IMM_J    = 3'd4,
        IMM_NONE = 3'd5                             // Immediate reads as zero
    } imm_fmt_e;

    // Field view in instruction bit order
    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        opcode_e              opcode;
    } instr_fields_t;

endpackage
